// ==== hdl/regfile_macros.svh ====
`ifndef REGFILE_MACROS_SVH
`define REGFILE_MACROS_SVH

// register width in bits.
`define RF_WORD_W 16

// general, segment and internal registers together.
`define RF_NUM_REGS 16

// architectural flags kept by the core.
`define RF_FLAGS_W 9

// cs and ip come out of reset at the top of memory.
`define RF_CS_RESET 16'hf000
`define RF_IP_RESET 16'hfff0

`endif

// ==== hdl/regfile_pkg.sv ====
`default_nettype none

`include "regfile_macros.svh"

package regfile_pkg;

  // one address word, read as a register index or as a byte selector.
  // in the byte view, bank is the pair {ext, hi}.
  typedef union packed {
    logic [3:0] word;
    struct packed {
      logic       ext;
      logic       hi;
      logic [1:0] idx;
    } bsel;
  } reg_addr_u;

  // main write port plus the dx high-half strobe.
  typedef struct packed {
    logic                    wr;
    logic                    word_op;
    reg_addr_u               addr;
    logic [2*`RF_WORD_W-1:0] data;
    logic                    wrhi;
  } wr_req_t;

  typedef struct packed {
    reg_addr_u addr;
    logic      byte_sel;
  } rd_req_t;

  // per-register byte lane enables.
  typedef struct packed {
    logic lo;
    logic hi;
  } lane_we_t;

  typedef logic [`RF_NUM_REGS-1:0][`RF_WORD_W-1:0] reg_bank_t;

endpackage

`default_nettype wire

// ==== hdl/reg_write_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regfile_macros.svh"

module reg_write_decode import regfile_pkg::*; (
  input  wire wr_req_t              wr_req,
  input  wire logic                 wr_ip0,
  input  wire logic [`RF_WORD_W-1:0] ip,
  output lane_we_t                  we    [`RF_NUM_REGS],
  output logic [`RF_WORD_W-1:0]     wdata [`RF_NUM_REGS]
);

  localparam int HALF = `RF_WORD_W / 2;
  localparam int DX_IDX = 2;
  localparam int IP_COPY_IDX = 14;

  logic [1:0]      bank;
  logic [3:0]      hi_idx;
  logic [HALF-1:0] byte_in;

  assign bank = {wr_req.addr.bsel.ext, wr_req.addr.bsel.hi};
  assign hi_idx = {2'b00, wr_req.addr.bsel.idx};
  assign byte_in = wr_req.data[HALF-1:0];

  always_comb begin
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      we[i] = '0;
      wdata[i] = '0;
    end

    if (wr_req.wr) begin
      if (wr_req.word_op) begin
        we[wr_req.addr.word] = '{lo: 1'b1, hi: 1'b1};
        wdata[wr_req.addr.word] = wr_req.data[`RF_WORD_W-1:0];
      end else begin
        case (bank)
          // segment registers take the byte sign-extended.
          2'b10: begin
            we[wr_req.addr.word] = '{lo: 1'b1, hi: 1'b1};
            wdata[wr_req.addr.word] = {{HALF{byte_in[HALF-1]}}, byte_in};
          end
          // ah, ch, dh, bh.
          2'b01: begin
            we[hi_idx].hi = 1'b1;
            wdata[hi_idx] = {byte_in, {HALF{1'b0}}};
          end
          default: begin
            we[wr_req.addr.word].lo = 1'b1;
            wdata[wr_req.addr.word] = {{HALF{1'b0}}, byte_in};
          end
        endcase
      end
    end

    // later assignments win over the main write.
    if (wr_req.wrhi) begin
      we[DX_IDX] = '{lo: 1'b1, hi: 1'b1};
      wdata[DX_IDX] = wr_req.data[2*`RF_WORD_W-1:`RF_WORD_W];
    end

    if (wr_ip0) begin
      we[IP_COPY_IDX] = '{lo: 1'b1, hi: 1'b1};
      wdata[IP_COPY_IDX] = ip;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reg_slice.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regfile_macros.svh"

module reg_slice import regfile_pkg::*; #(
  parameter logic [`RF_WORD_W-1:0] RESET_VALUE = '0
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire lane_we_t              we,
  input  wire logic [`RF_WORD_W-1:0] wdata,
  output logic [`RF_WORD_W-1:0]      q
);

  localparam int HALF = `RF_WORD_W / 2;

  // each byte lane updates on its own.
  always_ff @(posedge clk) begin
    if (rst) begin
      q <= RESET_VALUE;
    end else begin
      if (we.lo) begin
        q[HALF-1:0] <= wdata[HALF-1:0];
      end
      if (we.hi) begin
        q[`RF_WORD_W-1:HALF] <= wdata[`RF_WORD_W-1:HALF];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reg_read_port.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regfile_macros.svh"

module reg_read_port import regfile_pkg::*; (
  input  wire reg_bank_t        bank,
  input  wire rd_req_t          req,
  output logic [`RF_WORD_W-1:0] q
);

  localparam int HALF = `RF_WORD_W / 2;

  logic [3:0]      hi_idx;
  logic [HALF-1:0] byte_val;
  logic            byte_mode;

  assign hi_idx = {2'b00, req.addr.bsel.idx};

  // ah..bh live in the upper half of registers 0 to 3.
  assign byte_val = req.addr.bsel.hi ? bank[hi_idx][`RF_WORD_W-1:HALF]
                                     : bank[req.addr.word][HALF-1:0];

  // segment and internal registers are always read whole.
  assign byte_mode = req.byte_sel && !req.addr.bsel.ext;

  assign q = byte_mode ? {{HALF{byte_val[HALF-1]}}, byte_val}
                       : bank[req.addr.word];

endmodule

`default_nettype wire

// ==== hdl/reg_side_ports.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regfile_macros.svh"

module reg_side_ports import regfile_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire reg_bank_t             bank,
  input  wire wr_req_t               wr_req,
  input  wire logic [1:0]            addr_s,
  input  wire logic                  wrfl,
  input  wire logic [`RF_FLAGS_W-1:0] iflags,
  output logic [`RF_WORD_W-1:0]      s,
  output logic [`RF_WORD_W-1:0]      cs,
  output logic [`RF_WORD_W-1:0]      ip,
  output logic [`RF_FLAGS_W-1:0]     flags,
  output logic                       cx_zero
);

  localparam logic [3:0] CX_IDX = 4'd1;
  localparam logic [3:0] CS_IDX = 4'd9;
  localparam logic [3:0] IP_IDX = 4'd15;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (wrfl) begin
      flags <= iflags;
    end
  end

  // es, cs, ss, ds sit at 8..11.
  assign s = bank[{2'b10, addr_s}];
  assign cs = bank[CS_IDX];
  assign ip = bank[IP_IDX];

  // loop instructions see the count being written this cycle.
  assign cx_zero = (wr_req.addr.word == CX_IDX) ? (wr_req.data[`RF_WORD_W-1:0] == '0)
                                                : (bank[CX_IDX] == '0);

endmodule

`default_nettype wire

// ==== hdl/regfile_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regfile_macros.svh"

module regfile_top import regfile_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire wr_req_t               wr_req,
  input  wire logic                  wr_ip0,
  input  wire logic                  wrfl,
  input  wire logic [`RF_FLAGS_W-1:0] iflags,
  input  wire rd_req_t               rd_a,
  input  wire rd_req_t               rd_b,
  input  wire rd_req_t               rd_c,
  input  wire logic [1:0]            addr_s,
  output wire logic [`RF_WORD_W-1:0] a,
  output wire logic [`RF_WORD_W-1:0] b,
  output wire logic [`RF_WORD_W-1:0] c,
  output wire logic [`RF_WORD_W-1:0] s,
  output wire logic [`RF_WORD_W-1:0] cs,
  output wire logic [`RF_WORD_W-1:0] ip,
  output wire logic [`RF_FLAGS_W-1:0] flags,
  output wire logic                  cx_zero
);

  lane_we_t              we    [`RF_NUM_REGS];
  logic [`RF_WORD_W-1:0] wdata [`RF_NUM_REGS];
  wire reg_bank_t        bank;

  reg_write_decode u_decode (
    .wr_req (wr_req),
    .wr_ip0 (wr_ip0),
    .ip     (ip),
    .we     (we),
    .wdata  (wdata)
  );

  for (genvar i = 0; i < `RF_NUM_REGS; i++) begin : g_slice
    // cs and ip start the core at f000:fff0.
    localparam logic [`RF_WORD_W-1:0] RST_V = (i == 9)  ? `RF_CS_RESET :
                                              (i == 15) ? `RF_IP_RESET : '0;

    reg_slice #(
      .RESET_VALUE (RST_V)
    ) u_slice (
      .clk   (clk),
      .rst   (rst),
      .we    (we[i]),
      .wdata (wdata[i]),
      .q     (bank[i])
    );
  end

  reg_read_port u_port_a (
    .bank (bank),
    .req  (rd_a),
    .q    (a)
  );

  reg_read_port u_port_b (
    .bank (bank),
    .req  (rd_b),
    .q    (b)
  );

  reg_read_port u_port_c (
    .bank (bank),
    .req  (rd_c),
    .q    (c)
  );

  reg_side_ports u_side (
    .clk     (clk),
    .rst     (rst),
    .bank    (bank),
    .wr_req  (wr_req),
    .addr_s  (addr_s),
    .wrfl    (wrfl),
    .iflags  (iflags),
    .s       (s),
    .cs      (cs),
    .ip      (ip),
    .flags   (flags),
    .cx_zero (cx_zero)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk
);

  // 4 ns period.
  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

endmodule

`default_nettype wire

// ==== tests/regfile_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "regfile_macros.svh"

module regfile_tb import regfile_pkg::*; ();

  localparam int MAX_CYCLES = 1200;

  wire              clk;
  logic             rst = 1'b1;
  wr_req_t          wr_req;
  logic             wr_ip0;
  logic             wrfl;
  logic [8:0]       iflags;
  rd_req_t          rd_a;
  rd_req_t          rd_b;
  rd_req_t          rd_c;
  logic [1:0]       addr_s;
  wire logic [15:0] a;
  wire logic [15:0] b;
  wire logic [15:0] c;
  wire logic [15:0] s;
  wire logic [15:0] cs;
  wire logic [15:0] ip;
  wire logic [8:0]  flags;
  wire logic        cx_zero;

  logic [15:0] shadow [16];
  logic [8:0]  shadow_flags;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int          test_err_base = 0;

  tb_clkgen u_clk (.clk(clk));

  regfile_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .wr_req  (wr_req),
    .wr_ip0  (wr_ip0),
    .wrfl    (wrfl),
    .iflags  (iflags),
    .rd_a    (rd_a),
    .rd_b    (rd_b),
    .rd_c    (rd_c),
    .addr_s  (addr_s),
    .a       (a),
    .b       (b),
    .c       (c),
    .s       (s),
    .cs      (cs),
    .ip      (ip),
    .flags   (flags),
    .cx_zero (cx_zero)
  );

  function automatic logic [15:0] sext8(input logic [7:0] v);
    return {{8{v[7]}}, v};
  endfunction

  // expected operand port value from the shadow registers.
  function automatic logic [15:0] expect_read(input rd_req_t r);
    logic [3:0] addr;
    addr = r.addr.word;
    if (r.byte_sel && !addr[3]) begin
      if (addr[2]) begin
        return sext8(shadow[addr[1:0]][15:8]);
      end
      return sext8(shadow[addr][7:0]);
    end
    return shadow[addr];
  endfunction

  // the count being written to cx bypasses the stored one.
  function automatic logic expect_cx_zero();
    if (wr_req.addr.word == 4'd1) begin
      return wr_req.data[15:0] == 16'h0;
    end
    return shadow[1] == 16'h0;
  endfunction

  function automatic void reset_shadow();
    for (int i = 0; i < 16; i++) begin
      shadow[i] = 16'h0;
    end
    shadow[9] = `RF_CS_RESET;
    shadow[15] = `RF_IP_RESET;
    shadow_flags = 9'h0;
  endfunction

  // state after the next rising edge.
  function automatic void update_shadow();
    logic [3:0]  addr;
    logic [7:0]  lo_byte;
    logic [15:0] ip_now;
    addr = wr_req.addr.word;
    lo_byte = wr_req.data[7:0];
    ip_now = shadow[15];
    if (wr_req.wr) begin
      if (wr_req.word_op) begin
        shadow[addr] = wr_req.data[15:0];
      end else if (addr[3:2] == 2'b10) begin
        shadow[addr] = sext8(lo_byte);
      end else if (addr[3:2] == 2'b01) begin
        shadow[addr[1:0]][15:8] = lo_byte;
      end else begin
        shadow[addr][7:0] = lo_byte;
      end
    end
    if (wr_req.wrhi) begin
      shadow[2] = wr_req.data[31:16];
    end
    if (wr_ip0) begin
      shadow[14] = ip_now;
    end
    if (wrfl) begin
      shadow_flags = iflags;
    end
  endfunction

  function automatic wr_req_t make_write(input logic wr, input logic word_op,
                                         input logic [3:0] addr, input logic [31:0] data,
                                         input logic wrhi);
    wr_req_t w;
    w.wr = wr;
    w.word_op = word_op;
    w.addr.word = addr;
    w.data = data;
    w.wrhi = wrhi;
    return w;
  endfunction

  function automatic rd_req_t make_read(input logic [3:0] addr, input logic byte_sel);
    rd_req_t r;
    r.addr.word = addr;
    r.byte_sel = byte_sel;
    return r;
  endfunction

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // outputs are settled by the falling edge.
  always @(negedge clk) begin
    if (rst) begin
      reset_shadow();
    end else begin
      check_value("port a", a, expect_read(rd_a));
      check_value("port b", b, expect_read(rd_b));
      check_value("port c", c, expect_read(rd_c));
      check_value("port s", s, shadow[8 + addr_s]);
      check_value("cs", cs, shadow[9]);
      check_value("ip", ip, shadow[15]);
      check_value("flags", {7'b0, flags}, {7'b0, shadow_flags});
      check_value("cx_zero", {15'b0, cx_zero}, {15'b0, expect_cx_zero()});
      update_shadow();
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // port a reads the focus register, b, c and s read random ones.
  task automatic drive(input wr_req_t w, input logic ip0, input logic fl,
                       input logic [8:0] fv, input logic [3:0] focus, input logic byte_rd);
    logic [31:0] rnd;
    rnd = $urandom;
    @(posedge clk);
    wr_req <= w;
    wr_ip0 <= ip0;
    wrfl <= fl;
    iflags <= fv;
    rd_a <= make_read(focus, byte_rd);
    rd_b <= make_read(rnd[3:0], byte_rd);
    rd_c <= make_read(rnd[7:4], rnd[8]);
    addr_s <= rnd[10:9];
  endtask

  task automatic idle(input logic [3:0] focus, input logic byte_rd);
    drive(make_write(1'b0, 1'b0, 4'd0, 32'h0, 1'b0), 1'b0, 1'b0, 9'h0, focus, byte_rd);
  endtask

  task automatic end_test(input string name);
    idle(4'd0, 1'b0);
    @(posedge clk);
    if (errors == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [3:0]  prev;
    void'($urandom(32'h453d));
    wr_req = '0;
    wr_ip0 = 1'b0;
    wrfl = 1'b0;
    iflags = 9'h0;
    rd_a = '0;
    rd_b = '0;
    rd_c = '0;
    addr_s = 2'b00;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 32; i++) begin
      idle(i[3:0], i[4]);
    end
    end_test("reset values");

    prev = 4'd0;
    repeat (64) begin
      rnd = $urandom;
      drive(make_write(1'b1, 1'b1, rnd[3:0], $urandom, 1'b0), 1'b0, 1'b0, 9'h0, prev, 1'b0);
      prev = rnd[3:0];
    end
    end_test("word writes");

    // three passes over every bank and index.
    for (int i = 0; i < 48; i++) begin
      drive(make_write(1'b1, 1'b0, i[3:0], $urandom, 1'b0), 1'b0, 1'b0, 9'h0, prev, 1'b1);
      prev = i[3:0];
    end
    for (int i = 0; i < 16; i++) begin
      idle(i[3:0], 1'b1);
    end
    end_test("byte writes and byte reads");

    drive(make_write(1'b1, 1'b1, 4'd2, 32'hbeef_1234, 1'b1), 1'b0, 1'b0, 9'h0, 4'd2, 1'b0);
    idle(4'd2, 1'b0);
    drive(make_write(1'b1, 1'b0, 4'd2, 32'h5a5a_00c3, 1'b1), 1'b0, 1'b0, 9'h0, 4'd2, 1'b0);
    idle(4'd2, 1'b0);
    drive(make_write(1'b1, 1'b0, 4'd6, 32'h0f0f_0077, 1'b1), 1'b0, 1'b0, 9'h0, 4'd2, 1'b0);
    idle(4'd2, 1'b0);
    drive(make_write(1'b1, 1'b1, 4'd14, 32'h0000_abcd, 1'b0), 1'b1, 1'b0, 9'h0, 4'd14, 1'b0);
    idle(4'd14, 1'b0);
    drive(make_write(1'b1, 1'b0, 4'd14, 32'h0000_0081, 1'b0), 1'b1, 1'b0, 9'h0, 4'd14, 1'b0);
    idle(4'd14, 1'b0);
    // ip copy takes ip from before a same-cycle write to ip.
    drive(make_write(1'b1, 1'b1, 4'd15, 32'h0000_1234, 1'b0), 1'b1, 1'b0, 9'h0, 4'd14, 1'b0);
    drive(make_write(1'b0, 1'b0, 4'd0, 32'h0, 1'b0), 1'b1, 1'b0, 9'h0, 4'd14, 1'b0);
    idle(4'd14, 1'b0);
    end_test("override priority");

    drive(make_write(1'b1, 1'b1, 4'd1, 32'h0000_0005, 1'b0), 1'b0, 1'b0, 9'h0, 4'd1, 1'b0);
    drive(make_write(1'b0, 1'b1, 4'd1, 32'h0000_0000, 1'b0), 1'b0, 1'b0, 9'h0, 4'd1, 1'b0);
    drive(make_write(1'b0, 1'b1, 4'd1, 32'h0000_0007, 1'b0), 1'b0, 1'b0, 9'h0, 4'd1, 1'b0);
    idle(4'd1, 1'b0);
    drive(make_write(1'b1, 1'b1, 4'd1, 32'h0000_0000, 1'b0), 1'b0, 1'b0, 9'h0, 4'd1, 1'b0);
    idle(4'd1, 1'b0);
    repeat (24) begin
      rnd = $urandom;
      drive(make_write(rnd[4], 1'b1, rnd[5] ? 4'd1 : rnd[3:0], rnd[6] ? 32'h0 : $urandom,
                       1'b0), 1'b0, 1'b0, 9'h0, 4'd1, 1'b0);
    end
    end_test("cx_zero");

    drive(make_write(1'b0, 1'b0, 4'd0, 32'h0, 1'b0), 1'b0, 1'b1, 9'h1a5, 4'd0, 1'b0);
    idle(4'd0, 1'b0);
    idle(4'd0, 1'b0);
    repeat (16) begin
      rnd = $urandom;
      drive(make_write(1'b0, 1'b0, 4'd0, 32'h0, 1'b0), 1'b0, rnd[9], rnd[8:0], 4'd0, 1'b0);
    end
    end_test("flags");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/regfile_pkg.sv
hdl/reg_write_decode.sv
hdl/reg_slice.sv
hdl/reg_read_port.sv
hdl/reg_side_ports.sv
hdl/regfile_top.sv
tests/tb_clkgen.sv
tests/regfile_tb.sv
